// File: busWriter.sv
module busWriter (
  input  logic       clk,
  input  logic       rst,
  input  logic       write,
  input  logic       dc,
  input  logic [7:0] byteIn,
  output logic       dcx,
  output logic       wrx,
  output logic [7:0] data,
  output logic       writeDone
);

  // two phases per write: wrx low, then wrx high
  // the panel latches dcx and data on the rising edge of wrx
  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      dcx       <= 1'b1;
      wrx       <= 1'b1;
      data      <= 8'h00;
      writeDone <= 1'b0;
    end else begin
      writeDone <= 1'b0;
      if (write) begin
        // setup phase, dcx and data change while wrx falls
        dcx  <= dc;
        data <= byteIn;
        wrx  <= 1'b0;
      end else if (!wrx) begin
        // latch phase, data and dcx keep their value
        wrx       <= 1'b1;
        writeDone <= 1'b1;
      end
    end
  end

endmodule

// File: delayTimer.sv
module delayTimer (
  input  logic           clk,
  input  logic           rst,
  input  logic           delayLoad,
  input  lcdPkg::delay_t delayValue,
  output logic           delayDone
);
  import lcdPkg::*;

  delay_t count;

  // count holds the cycles left, including the current one
  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      count <= '0;
    end else if (delayLoad) begin
      count <= delayValue;
    end else if (count != '0) begin
      count <= count - 1'b1;
    end
  end

  // a load of W in cycle N reaches 1 in cycle N+W
  assign delayDone = (count == delay_t'(1));

endmodule

// File: lcdController.sv
module lcdController (
  input  logic            clk,
  input  logic            rst,
  input  logic            start,
  input  lcdPkg::lcdOp_t  op,
  input  lcdPkg::window_t window,
  input  lcdPkg::rgb565_t color,
  output lcdPkg::lcdBus_t lcd,
  output logic            busy,
  output logic            ack
);
  import lcdPkg::*;

  lcdOp_t                    scriptOp;
  logic [stepIndexWidth-1:0] index;
  step_t                     step;
  logic                      write;
  logic                      dc;
  logic [7:0]                byteOut;
  logic                      writeDone;
  logic                      delayLoad;
  delay_t                    delayValue;
  logic                      delayDone;
  logic                      csx;
  logic                      dcx;
  logic                      wrx;
  logic [7:0]                data;

  lcdSequencer uSequencer (
    .clk        (clk),
    .rst        (rst),
    .start      (start),
    .op         (op),
    .step       (step),
    .writeDone  (writeDone),
    .delayDone  (delayDone),
    .scriptOp   (scriptOp),
    .index      (index),
    .write      (write),
    .dc         (dc),
    .byteOut    (byteOut),
    .delayLoad  (delayLoad),
    .delayValue (delayValue),
    .csx        (csx),
    .busy       (busy),
    .ack        (ack)
  );

  lcdScript uScript (
    .op     (scriptOp),
    .index  (index),
    .window (window),
    .color  (color),
    .step   (step)
  );

  busWriter uWriter (
    .clk       (clk),
    .rst       (rst),
    .write     (write),
    .dc        (dc),
    .byteIn    (byteOut),
    .dcx       (dcx),
    .wrx       (wrx),
    .data      (data),
    .writeDone (writeDone)
  );

  delayTimer uTimer (
    .clk        (clk),
    .rst        (rst),
    .delayLoad  (delayLoad),
    .delayValue (delayValue),
    .delayDone  (delayDone)
  );

  // chip select from the sequencer, the rest of the pins from the writer
  assign lcd = '{csx: csx, dcx: dcx, wrx: wrx, data: data};

endmodule

// File: lcdPkg.sv
package lcdPkg;

  // panel command codes
  localparam logic [7:0] cmdSoftReset   = 8'h01;
  localparam logic [7:0] cmdSleepIn     = 8'h10;
  localparam logic [7:0] cmdSleepOut    = 8'h11;
  localparam logic [7:0] cmdDispOff     = 8'h28;
  localparam logic [7:0] cmdDispOn      = 8'h29;
  localparam logic [7:0] cmdColumnSet   = 8'h2A;
  localparam logic [7:0] cmdPageSet     = 8'h2B;
  localparam logic [7:0] cmdMemWrite    = 8'h2C;
  localparam logic [7:0] cmdAccessCtrl  = 8'h36;
  localparam logic [7:0] cmdPixelFormat = 8'h3A;

  // 16 bits per pixel
  localparam logic [7:0] paramPixelFormat = 8'h55;
  // row/column exchange and BGR order
  localparam logic [7:0] paramAccessCtrl  = 8'hB8;

  // wait counts, wide enough for the longest wait
  localparam int delayWidth = 21;

  typedef logic [delayWidth-1:0] delay_t;

  // waits in clock cycles after a command
  localparam delay_t waitReset    = delay_t'(1200000);
  localparam delay_t waitSleepIn  = delay_t'(1200000);
  localparam delay_t waitSleepOut = delay_t'(50000);
  localparam delay_t waitDisp     = delay_t'(50000);

  localparam int stepIndexWidth = 5;

  typedef enum logic [1:0] {
    opInit,
    opDispOff,
    opDispOn,
    opPixel
  } lcdOp_t;

  // drawing window, inclusive bounds
  typedef struct packed {
    logic [15:0] xStart;
    logic [15:0] xEnd;
    logic [15:0] yStart;
    logic [15:0] yEnd;
  } window_t;

  typedef logic [15:0] rgb565_t;

  // one byte written to the panel, with the pause that follows it
  typedef struct packed {
    logic       isLast;
    logic       dc;
    logic [7:0] data;
    // 0 means the next write follows at once
    delay_t     waitCycles;
  } step_t;

  typedef struct packed {
    logic       csx;
    logic       dcx;
    logic       wrx;
    logic [7:0] data;
  } lcdBus_t;

endpackage

// File: lcdScript.sv
module lcdScript (
  input  lcdPkg::lcdOp_t                    op,
  input  logic [lcdPkg::stepIndexWidth-1:0] index,
  input  lcdPkg::window_t                   window,
  input  lcdPkg::rgb565_t                   color,
  output lcdPkg::step_t                     step
);
  import lcdPkg::*;

  // command byte, optionally followed by a wait
  function automatic step_t cmdStep(
    input logic [7:0] code,
    input delay_t     w,
    input logic       last
  );
    cmdStep = '{isLast: last, dc: 1'b0, data: code, waitCycles: w};
  endfunction

  // parameter byte, never followed by a wait
  function automatic step_t parStep(
    input logic [7:0] b,
    input logic       last
  );
    parStep = '{isLast: last, dc: 1'b1, data: b, waitCycles: '0};
  endfunction

  always_comb begin
    // out of range index ends the operation
    step = '{isLast: 1'b1, default: '0};
    case (op)
      opInit: begin
        case (index)
          5'd0: step = cmdStep(cmdSleepIn, waitSleepIn, 1'b0);
          5'd1: step = cmdStep(cmdSoftReset, waitReset, 1'b0);
          5'd2: step = cmdStep(cmdSleepOut, waitSleepOut, 1'b0);
          5'd3: step = cmdStep(cmdPixelFormat, '0, 1'b0);
          5'd4: step = parStep(paramPixelFormat, 1'b0);
          5'd5: step = cmdStep(cmdAccessCtrl, '0, 1'b0);
          5'd6: step = parStep(paramAccessCtrl, 1'b0);
          5'd7: step = cmdStep(cmdDispOn, '0, 1'b1);
          default: ;
        endcase
      end

      opDispOff: begin
        case (index)
          5'd0: step = cmdStep(cmdDispOff, waitDisp, 1'b0);
          5'd1: step = cmdStep(cmdSleepIn, waitSleepIn, 1'b1);
          default: ;
        endcase
      end

      opDispOn: begin
        case (index)
          5'd0: step = cmdStep(cmdSleepOut, waitSleepOut, 1'b0);
          5'd1: step = cmdStep(cmdDispOn, waitDisp, 1'b1);
          default: ;
        endcase
      end

      opPixel: begin
        // window bounds and colour go out high byte first
        case (index)
          5'd0:  step = cmdStep(cmdColumnSet, '0, 1'b0);
          5'd1:  step = parStep(window.xStart[15:8], 1'b0);
          5'd2:  step = parStep(window.xStart[7:0], 1'b0);
          5'd3:  step = parStep(window.xEnd[15:8], 1'b0);
          5'd4:  step = parStep(window.xEnd[7:0], 1'b0);
          5'd5:  step = cmdStep(cmdPageSet, '0, 1'b0);
          5'd6:  step = parStep(window.yStart[15:8], 1'b0);
          5'd7:  step = parStep(window.yStart[7:0], 1'b0);
          5'd8:  step = parStep(window.yEnd[15:8], 1'b0);
          5'd9:  step = parStep(window.yEnd[7:0], 1'b0);
          5'd10: step = cmdStep(cmdMemWrite, '0, 1'b0);
          5'd11: step = parStep(color[15:8], 1'b0);
          5'd12: step = parStep(color[7:0], 1'b1);
          default: ;
        endcase
      end

      default: ;
    endcase
  end

endmodule

// File: lcdSequencer.sv
module lcdSequencer (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              start,
  input  lcdPkg::lcdOp_t                    op,
  input  lcdPkg::step_t                     step,
  input  logic                              writeDone,
  input  logic                              delayDone,
  output lcdPkg::lcdOp_t                    scriptOp,
  output logic [lcdPkg::stepIndexWidth-1:0] index,
  output logic                              write,
  output logic                              dc,
  output logic [7:0]                        byteOut,
  output logic                              delayLoad,
  output lcdPkg::delay_t                    delayValue,
  output logic                              csx,
  output logic                              busy,
  output logic                              ack
);
  import lcdPkg::*;

  typedef enum logic [2:0] {
    stIdle,
    stSelect,
    stWrite,
    stWaitWrite,
    stWaitDelay,
    stRelease,
    stDone
  } state_t;

  state_t state;
  state_t stateNext;
  logic   accept;
  logic   stepHasWait;
  logic   stepFinished;

  // a start is taken only when no operation is running
  assign accept      = start && (state == stIdle || state == stDone);
  assign stepHasWait = (step.waitCycles != '0);

  // the current byte is written and its wait, if any, is over
  assign stepFinished = (state == stWaitWrite && writeDone && !stepHasWait) ||
                        (state == stWaitDelay && delayDone);

  always_comb begin
    stateNext = state;
    case (state)
      stIdle: begin
        if (start) stateNext = stSelect;
      end
      stSelect: stateNext = stWrite;
      stWrite:  stateNext = stWaitWrite;
      stWaitWrite: begin
        if (writeDone) begin
          if (stepHasWait) stateNext = stWaitDelay;
          else if (step.isLast) stateNext = stRelease;
          else stateNext = stWrite;
        end
      end
      stWaitDelay: begin
        if (delayDone) stateNext = step.isLast ? stRelease : stWrite;
      end
      stRelease: stateNext = stDone;
      stDone: begin
        // back to back operations skip the idle cycle
        stateNext = start ? stSelect : stIdle;
      end
      default: stateNext = stIdle;
    endcase
  end

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      state    <= stIdle;
      scriptOp <= opInit;
      index    <= '0;
      csx      <= 1'b1;
    end else begin
      state <= stateNext;
      if (accept) begin
        scriptOp <= op;
        index    <= '0;
        csx      <= 1'b0;
      end else if (stepFinished) begin
        if (step.isLast) csx <= 1'b1;
        else index <= index + 1'b1;
      end
    end
  end

  // one strobe per step, the byte comes straight from the script
  assign write   = (state == stWrite);
  assign dc      = step.dc;
  assign byteOut = step.data;

  assign delayLoad  = (state == stWaitWrite) && writeDone && stepHasWait;
  assign delayValue = step.waitCycles;

  assign busy = (state != stIdle) && (state != stDone);
  assign ack  = (state == stDone);

endmodule

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_lcdController -f tb.f -o simv
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

output=$(./obj_dir/simv)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx '>>> PASS'; then
  exit 0
fi
exit 1

// File: tb.f
lcdPkg.sv
lcdScript.sv
delayTimer.sv
busWriter.sv
lcdSequencer.sv
lcdController.sv
tbBusMonitor.sv
tb_lcdController.sv

// File: tbBusMonitor.sv
module tbBusMonitor (
  input  logic            clk,
  input  logic            rst,
  input  lcdPkg::lcdBus_t lcd,
  input  logic            start,
  input  logic            busy,
  input  logic            ack,
  output int              capCount,
  output logic            capDc [32],
  output logic [7:0]      capData [32],
  output int              capGap [32],
  output int              ackGap,
  output int              ackCount,
  output int              frameErrors
);
  timeunit 1ns;
  timeprecision 100ps;
  import lcdPkg::*;

  int   cycle;
  int   lastRise;
  logic prevWrx;
  logic prevBusy;
  logic inOp;

  // sampled on the falling edge, half a period away from any bus change
  always @(negedge clk) begin
    if (rst) begin
      cycle       = 0;
      lastRise    = 0;
      prevWrx     = 1'b1;
      prevBusy    = 1'b0;
      inOp        = 1'b0;
      capCount    = 0;
      ackGap      = 0;
      ackCount    = 0;
      frameErrors = 0;
    end else begin
      cycle++;
      // the controller takes a start only while it is not busy
      if (start && !busy) begin
        inOp     = 1'b1;
        capCount = 0;
      end
      if (!lcd.csx && !inOp) begin
        frameErrors++;
        $display("csx is low outside an operation at cycle %0d", cycle);
      end
      // the panel latches on the rising edge of wrx
      if (lcd.wrx && !prevWrx && !lcd.csx) begin
        if (capCount < 32) begin
          capDc[capCount]   = lcd.dcx;
          capData[capCount] = lcd.data;
          capGap[capCount]  = cycle - lastRise;
        end
        capCount++;
        lastRise = cycle;
      end
      if (prevBusy && !busy && !ack) begin
        frameErrors++;
        $display("busy fell without an ack at cycle %0d", cycle);
      end
      if (ack) begin
        if (!prevBusy) begin
          frameErrors++;
          $display("ack came without a busy operation at cycle %0d", cycle);
        end
        ackCount++;
        ackGap = cycle - lastRise;
        inOp   = 1'b0;
      end
      prevWrx  = lcd.wrx;
      prevBusy = busy;
    end
  end

endmodule

// File: tb_lcdController.sv
module tb_lcdController;
  timeunit 1ns;
  timeprecision 100ps;
  import lcdPkg::*;

  localparam int rowCount  = 8;
  localparam int maxWrites = 32;

  typedef struct {
    lcdOp_t  op;
    window_t win;
    rgb565_t color;
    string   name;
  } row_t;

  logic       clk;
  logic       rst;
  logic       start;
  lcdOp_t     op;
  window_t    window;
  rgb565_t    color;
  lcdBus_t    lcd;
  logic       busy;
  logic       ack;
  int         capCount;
  logic       capDc [maxWrites];
  logic [7:0] capData [maxWrites];
  int         capGap [maxWrites];
  int         ackGap;
  int         ackCount;
  int         frameErrors;
  row_t       stim [rowCount];
  logic       expDc [maxWrites];
  logic [7:0] expData [maxWrites];
  int         expWait [maxWrites];
  int         expCount;
  int         valueErrors;
  int         otherErrors;
  int         limitCycles;
  int         seed;

  lcdController DUT (
    .clk(clk), .rst(rst), .start(start), .op(op), .window(window),
    .color(color), .lcd(lcd), .busy(busy), .ack(ack)
  );

  tbBusMonitor busMon (
    .clk(clk), .rst(rst), .lcd(lcd), .start(start), .busy(busy), .ack(ack),
    .capCount(capCount), .capDc(capDc), .capData(capData), .capGap(capGap),
    .ackGap(ackGap), .ackCount(ackCount), .frameErrors(frameErrors)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic checkByte(input string name, input logic [7:0] expected,
                           input logic [7:0] actual);
    if (actual !== expected) begin
      valueErrors++;
      $display("ERR %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic checkFlag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      valueErrors++;
      $display("ERR %s: expected %b, actual %b", name, expected, actual);
    end
  endtask

  task automatic checkBus(input string name, input lcdBus_t expected, input lcdBus_t actual);
    if (actual !== expected) begin
      valueErrors++;
      $display("ERR %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic setRow(input int r, input lcdOp_t o, input window_t w, input rgb565_t c,
                        input string name);
    stim[r].op    = o;
    stim[r].win   = w;
    stim[r].color = c;
    stim[r].name  = name;
  endtask

  task automatic fillTable();
    logic [31:0] lo;
    logic [31:0] hi;
    lo = $random(seed);
    hi = $random(seed);
    setRow(0, opInit, '0, 16'h0000, "init");
    setRow(1, opPixel, {16'd0, 16'd239, 16'd0, 16'd319}, 16'hF800, "pixelRed");
    setRow(2, opPixel, {16'h0010, 16'h0020, 16'h0100, 16'h0140}, 16'h07E0, "pixelGreen");
    setRow(3, opPixel, {lo[15:0], lo[31:16], hi[15:0], hi[31:16]}, 16'h001F, "pixelBlue");
    setRow(4, opPixel, {16'h1234, 16'hABCD, 16'h5A5A, 16'hA5A5}, 16'h0000, "pixelBlack");
    setRow(5, opPixel, {16'hFFFF, 16'hFFFF, 16'hFFFF, 16'hFFFF}, 16'hFFFF, "pixelWhite");
    setRow(6, opDispOff, '0, 16'h0000, "dispOff");
    setRow(7, opDispOn, '0, 16'h0000, "dispOn");
  endtask

  task automatic addEntry(input logic dc, input logic [7:0] b, input int w);
    expDc[expCount]   = dc;
    expData[expCount] = b;
    expWait[expCount] = w;
    expCount++;
  endtask

  // expected writes of one row, as (dc, byte, minimum wait after it)
  task automatic buildExpected(input row_t r);
    expCount = 0;
    case (r.op)
      opInit: begin
        addEntry(1'b0, cmdSleepIn, int'(waitSleepIn));
        addEntry(1'b0, cmdSoftReset, int'(waitReset));
        addEntry(1'b0, cmdSleepOut, int'(waitSleepOut));
        addEntry(1'b0, cmdPixelFormat, 0);
        addEntry(1'b1, paramPixelFormat, 0);
        addEntry(1'b0, cmdAccessCtrl, 0);
        addEntry(1'b1, paramAccessCtrl, 0);
        addEntry(1'b0, cmdDispOn, 0);
      end
      opDispOff: begin
        addEntry(1'b0, cmdDispOff, int'(waitDisp));
        addEntry(1'b0, cmdSleepIn, int'(waitSleepIn));
      end
      opDispOn: begin
        addEntry(1'b0, cmdSleepOut, int'(waitSleepOut));
        addEntry(1'b0, cmdDispOn, int'(waitDisp));
      end
      default: begin
        addEntry(1'b0, cmdColumnSet, 0);
        addEntry(1'b1, r.win.xStart[15:8], 0);
        addEntry(1'b1, r.win.xStart[7:0], 0);
        addEntry(1'b1, r.win.xEnd[15:8], 0);
        addEntry(1'b1, r.win.xEnd[7:0], 0);
        addEntry(1'b0, cmdPageSet, 0);
        addEntry(1'b1, r.win.yStart[15:8], 0);
        addEntry(1'b1, r.win.yStart[7:0], 0);
        addEntry(1'b1, r.win.yEnd[15:8], 0);
        addEntry(1'b1, r.win.yEnd[7:0], 0);
        addEntry(1'b0, cmdMemWrite, 0);
        addEntry(1'b1, r.color[15:8], 0);
        addEntry(1'b1, r.color[7:0], 0);
      end
    endcase
  endtask

  task automatic runRow(input int r);
    string name;
    name = stim[r].name;
    buildExpected(stim[r]);
    @(posedge clk);
    #1;
    op     = stim[r].op;
    window = stim[r].win;
    color  = stim[r].color;
    start  = 1'b1;
    @(posedge clk);
    #1;
    start = 1'b0;
    // a second request in the middle of the operation must be dropped
    repeat (4) @(posedge clk);
    #1;
    start = 1'b1;
    @(posedge clk);
    #1;
    start = 1'b0;
    do @(negedge clk); while (!ack);
    // quiet cycles after ack, no further ack or write may show up
    repeat (6) @(negedge clk);
    checkFlag({name, " busy"}, 1'b0, busy);
    if (ackCount != r + 1) begin
      otherErrors++;
      $display("%s: %0d acks seen after %0d starts", name, ackCount, r + 1);
    end
    if (capCount != expCount) begin
      otherErrors++;
      $display("%s: %0d writes captured where %0d were due", name, capCount, expCount);
    end else begin
      for (int i = 0; i < expCount; i++) begin
        checkByte($sformatf("%s byte %0d", name, i), expData[i], capData[i]);
        checkFlag($sformatf("%s dcx %0d", name, i), expDc[i], capDc[i]);
        if (i > 0 && capGap[i] < expWait[i - 1]) begin
          otherErrors++;
          $display("%s: write %0d followed the previous one after only %0d cycles", name, i,
                   capGap[i]);
        end
      end
      if (ackGap < expWait[expCount - 1]) begin
        otherErrors++;
        $display("%s: ack came only %0d cycles after the last write", name, ackGap);
      end
    end
  endtask

  initial begin
    lcdBus_t idleBus;
    int      waitSum;
    rst         = 1'b1;
    start       = 1'b0;
    op          = opInit;
    window      = '0;
    color       = '0;
    seed        = 32'hee42_2683;
    valueErrors = 0;
    otherErrors = 0;
    fillTable();
    waitSum = 0;
    for (int r = 0; r < rowCount; r++) begin
      buildExpected(stim[r]);
      for (int i = 0; i < expCount; i++) waitSum += expWait[i];
    end
    limitCycles = waitSum + 200 * rowCount;
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;
    @(negedge clk);
    idleBus = '{csx: 1'b1, dcx: 1'b1, wrx: 1'b1, data: 8'h00};
    checkBus("reset bus", idleBus, lcd);
    checkFlag("reset busy", 1'b0, busy);
    checkFlag("reset ack", 1'b0, ack);
    for (int r = 0; r < rowCount; r++) runRow(r);
    $display("errors: %0d value, %0d other, %0d framing", valueErrors, otherErrors,
             frameErrors);
    if (valueErrors + otherErrors + frameErrors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  // watchdog sized from all waits of the table
  initial begin
    wait (limitCycles > 200);
    repeat (limitCycles) @(posedge clk);
    $display("run timed out after %0d cycles without ack", limitCycles);
    $display("errors: %0d value, %0d other, %0d framing", valueErrors, otherErrors,
             frameErrors);
    $display(">>> FAIL");
    $finish;
  end

endmodule
